/* compile.f */
source/matcalc_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/matrix_store.sv
source/matrix_input.sv
source/matrix_output.sv
source/matcalc_top.sv
test/matcalc_assert.sv
test/tb_matcalc.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_matcalc
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_matcalc.sv */
`timescale 1ns/100ps
// Matrix calculator testbench
// Directed tests through a UART host model, with a model of the store
// that supplies the expected readback bytes

module tb_matcalc;
    import matcalc_pkg::*;

    localparam int CLKS_PER_BIT   = 8;
    localparam int ERR_HOLD       = 200;
    localparam int BYTE_CYCLES    = 10 * CLKS_PER_BIT;
    localparam int RECV_LIMIT     = 4 * BYTE_CYCLES;
    localparam int LAMP_MARGIN    = 20;
    // About 190 bytes of 80 cycles when every matrix is 4x4
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RANDOM_SEED    = 4;
    // Digits in gfedcba order
    localparam logic [6:0] DIGIT_0 = 7'b011_1111;
    localparam logic [6:0] DIGIT_1 = 7'b000_0110;
    localparam logic [6:0] DIGIT_3 = 7'b100_1111;

    logic       clk;
    logic       rst_n;
    logic [2:0] dip_sw;
    logic       btn_confirm;
    logic       btn_back;
    logic       uart_rx;
    logic       uart_tx;
    logic [6:0] seg_display;
    logic [3:0] led_status;

    int    error_count;
    int    check_count;
    int    cycle_count;
    string test_name;
    int    host_rx_q[$];
    // Store model
    int    exp_m[NUM_SLOTS];
    int    exp_n[NUM_SLOTS];
    int    exp_elem[NUM_SLOTS][SLOT_ELEMS];
    int    exp_next;

    matcalc_top #(.clks_per_bit(CLKS_PER_BIT), .err_hold_cycles(ERR_HOLD)) dut0 (
        .clk(clk), .rst_n(rst_n), .dip_sw(dip_sw), .btn_confirm(btn_confirm),
        .btn_back(btn_back), .uart_rx(uart_rx), .uart_tx(uart_tx),
        .seg_display(seg_display), .led_status(led_status)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles in %s, errors: %0d",
                     cycle_count, test_name, error_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ====================
    // UART host model
    // ====================
    // Decodes every frame on uart_tx into host_rx_q
    initial begin : tx_monitor
        int value;
        forever begin
            @(negedge clk);
            if (rst_n && !uart_tx) begin
                value = 0;
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    value = value | (int'(uart_tx) << i);
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (!uart_tx) begin
                    error_count++;
                    $display("Framing error on uart_tx, stop bit was low in %s", test_name);
                end else begin
                    host_rx_q.push_back(value);
                end
            end
        end
    end

    task automatic send_byte(input int value);
        logic [9:0] frame;
        frame = {1'b1, 8'(value), 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic recv_byte(output int value);
        int waited;
        waited = 0;
        while (host_rx_q.size() == 0 && waited < RECV_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (host_rx_q.size() == 0) begin
            error_count++;
            $display("No byte came back on uart_tx within %0d cycles in %s",
                     RECV_LIMIT, test_name);
            value = -1;
        end else begin
            value = host_rx_q.pop_front();
        end
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("CHECK FAILED %s: %s expected %0d actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // ====================
    // Helpers
    // ====================
    function automatic int random_dim();
        return 1 + int'($urandom % 4);
    endfunction

    task automatic wait_cycles(input int count);
        repeat (count) @(negedge clk);
    endtask

    task automatic press_confirm(input logic [2:0] sw);
        dip_sw      = sw;
        btn_confirm = 1'b1;
        @(negedge clk);
        btn_confirm = 1'b0;
        @(negedge clk);
    endtask

    task automatic press_back();
        btn_back = 1'b1;
        @(negedge clk);
        btn_back = 1'b0;
        @(negedge clk);
    endtask

    task automatic enter_mode(input logic [2:0] sw, input logic [6:0] digit);
        press_back();
        press_confirm(sw);
        check_value("mode digit", int'(digit), int'(seg_display));
    endtask

    // Sends one matrix, optionally with a bad element before index bad_pos
    task automatic store_matrix(input int m, input int n, input int bad_pos);
        int elems[SLOT_ELEMS];
        int reply;
        send_byte(m);
        send_byte(n);
        for (int i = 0; i < m * n; i++) begin
            elems[i] = int'($urandom % 10);
            if (i == bad_pos) begin
                send_byte(12);
                wait_cycles(4);
                check_value("lamp after bad element", 1, int'(led_status[3]));
                check_value("code after bad element", int'(ERR_VALUE), int'(led_status[1:0]));
            end
            send_byte(elems[i]);
        end
        recv_byte(reply);
        check_value("slot answer", exp_next, reply);
        exp_m[exp_next] = m;
        exp_n[exp_next] = n;
        for (int i = 0; i < m * n; i++) begin
            exp_elem[exp_next][i] = elems[i];
        end
        exp_next = (exp_next + 1) % NUM_SLOTS;
    endtask

    task automatic readback_slot(input int slot);
        int value;
        send_byte(slot);
        recv_byte(value);
        check_value($sformatf("slot %0d rows", slot), exp_m[slot], value);
        recv_byte(value);
        check_value($sformatf("slot %0d cols", slot), exp_n[slot], value);
        for (int i = 0; i < exp_m[slot] * exp_n[slot]; i++) begin
            recv_byte(value);
            check_value($sformatf("slot %0d element %0d", slot, i), exp_elem[slot][i], value);
        end
    endtask

    task automatic wait_lamp_off();
        int waited;
        waited = 0;
        while (led_status[3] && waited < ERR_HOLD + LAMP_MARGIN) begin
            @(negedge clk);
            waited++;
        end
        check_value("lamp off after hold", 0, int'(led_status[3]));
        check_value("code cleared after hold", int'(ERR_NONE), int'(led_status[1:0]));
    endtask

    // ====================
    // Tests
    // ====================
    task automatic test_mode_control();
        test_name = "mode_control";
        check_value("digit after reset", int'(DIGIT_0), int'(seg_display));
        check_value("leds after reset", 0, int'(led_status));
        check_value("uart_tx after reset", 1, int'(uart_tx));
        press_confirm(3'd1);
        check_value("digit in input mode", int'(DIGIT_1), int'(seg_display));
        press_back();
        check_value("digit after back", int'(DIGIT_0), int'(seg_display));
        press_confirm(3'd6);
        check_value("digit after unused code", int'(DIGIT_0), int'(seg_display));
    endtask

    task automatic test_store_three();
        test_name = "store_three";
        enter_mode(3'd1, DIGIT_1);
        repeat (3) store_matrix(random_dim(), random_dim(), -1);
    endtask

    task automatic test_readback();
        test_name = "readback";
        enter_mode(3'd3, DIGIT_3);
        for (int s = 0; s < 3; s++) begin
            readback_slot(s);
        end
    endtask

    // Slot 3 is still empty here
    task automatic test_empty_slot();
        test_name = "empty_slot";
        enter_mode(3'd3, DIGIT_3);
        send_byte(3);
        wait_cycles(4);
        check_value("lamp for empty slot", 1, int'(led_status[3]));
        check_value("code for empty slot", int'(ERR_SLOT), int'(led_status[1:0]));
        wait_lamp_off();
        check_value("bytes sent for empty slot", 0, host_rx_q.size());
    endtask

    task automatic test_dim_error();
        test_name = "dim_error";
        enter_mode(3'd1, DIGIT_1);
        check_value("store full before fourth", 0, int'(led_status[2]));
        send_byte(5);
        wait_cycles(4);
        check_value("lamp for bad dimension", 1, int'(led_status[3]));
        check_value("code for bad dimension", int'(ERR_DIM), int'(led_status[1:0]));
        store_matrix(random_dim(), random_dim(), -1);
        check_value("store full after fourth", 1, int'(led_status[2]));
        enter_mode(3'd3, DIGIT_3);
        readback_slot(3);
    endtask

    // Fifth matrix wraps to slot 0 and carries one bad element
    task automatic test_value_error_wrap();
        int n;
        test_name = "value_error_wrap";
        n = random_dim();
        enter_mode(3'd1, DIGIT_1);
        store_matrix(3, n, (3 * n) / 2);
        enter_mode(3'd3, DIGIT_3);
        readback_slot(0);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        dip_sw      = 3'd0;
        btn_confirm = 1'b0;
        btn_back    = 1'b0;
        uart_rx     = 1'b1;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        exp_next    = 0;
        test_name   = "reset";
        void'($urandom(RANDOM_SEED));
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_mode_control();
        test_store_three();
        test_readback();
        test_empty_slot();
        test_dim_error();
        test_value_error_wrap();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* test/matcalc_assert.sv */
`timescale 1ns/100ps
// Concurrent checks on the UART transmit handshake and store writes,
// bound into the top level

module matcalc_assert (
    input logic clk,
    input logic rst_n,
    input logic tx_start,
    input logic tx_busy,
    input logic uart_tx,
    input logic wr_en,
    input logic commit
);

    // Transmitter takes a byte only when idle
    start_when_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_busy |-> !tx_start)
        else $error("tx_start was high while tx_busy was high");

    // Line idles high between frames
    idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> uart_tx)
        else $error("uart_tx was low while tx_busy was low");

    commit_after_write: assert property (@(posedge clk) disable iff (!rst_n) !(commit && wr_en))
        else $error("commit and wr_en were high together");

endmodule

bind matcalc_top matcalc_assert u_assert (
    .clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_busy(tx_busy),
    .uart_tx(uart_tx), .wr_en(wr_en), .commit(commit)
);

/* source/matcalc_top.sv */
`timescale 1ns/100ps
// Matrix calculator top level
// Mode control from switches and buttons, UART routing between the modes,
// timed error lamp and the mode digit on the seven-segment display

module matcalc_top #(
    parameter int clks_per_bit    = matcalc_pkg::CLKS_PER_BIT_DEFAULT,
    parameter int err_hold_cycles = matcalc_pkg::ERR_HOLD_DEFAULT
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] dip_sw,
    input  logic       btn_confirm,
    input  logic       btn_back,
    input  logic       uart_rx,
    output logic       uart_tx,
    output logic [6:0] seg_display,
    output logic [3:0] led_status
);
    import matcalc_pkg::*;

    typedef logic [$clog2(err_hold_cycles)-1:0] hold_cnt_t;

    mode_t     mode;
    mode_t     mode_next;
    logic      input_active;
    logic      display_active;
    byte_t     rx_data;
    logic      rx_valid;
    byte_t     tx_data;
    logic      tx_start;
    logic      tx_busy;
    byte_t     in_tx_data;
    byte_t     out_tx_data;
    logic      in_tx_start;
    logic      out_tx_start;
    slot_t     next_slot;
    slot_t     rd_slot;
    index_t    wr_index;
    index_t    rd_index;
    elem_t     wr_data;
    elem_t     rd_data;
    logic      wr_en;
    logic      commit;
    dim_t      commit_m;
    dim_t      commit_n;
    logic      q_valid;
    dim_t      q_m;
    dim_t      q_n;
    logic      store_full;
    logic      in_err_strobe;
    logic      out_err_strobe;
    err_t      in_err_code;
    err_t      out_err_code;
    err_t      err_latched;
    logic      err_lamp;
    hold_cnt_t err_timer;

    // ====================
    // Mode control
    // ====================
    always_comb begin
        mode_next = mode;
        case (mode)
            MODE_MENU: begin
                if (btn_confirm && dip_sw == SW_INPUT) begin
                    mode_next = MODE_INPUT;
                end else if (btn_confirm && dip_sw == SW_DISPLAY) begin
                    mode_next = MODE_DISPLAY;
                end
            end
            default: begin
                if (btn_back) mode_next = MODE_MENU;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) mode <= MODE_MENU;
        else mode <= mode_next;
    end

    assign input_active   = (mode == MODE_INPUT);
    assign display_active = (mode == MODE_DISPLAY);

    // Only the active mode reaches the transmitter
    assign tx_data  = display_active ? out_tx_data : in_tx_data;
    assign tx_start = (input_active && in_tx_start) || (display_active && out_tx_start);

    // ====================
    // Error lamp
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_lamp    <= 1'b0;
            err_latched <= ERR_NONE;
            err_timer   <= '0;
        end else if (in_err_strobe || out_err_strobe) begin
            // New error restarts the hold
            err_lamp    <= 1'b1;
            err_latched <= in_err_strobe ? in_err_code : out_err_code;
            err_timer   <= '0;
        end else if (err_lamp) begin
            if (err_timer == hold_cnt_t'(err_hold_cycles - 1)) begin
                err_lamp    <= 1'b0;
                err_latched <= ERR_NONE;
            end else begin
                err_timer <= err_timer + 1'b1;
            end
        end
    end

    always_comb begin
        case (mode)
            MODE_INPUT:   seg_display = SEG_DIGIT_1;
            MODE_DISPLAY: seg_display = SEG_DIGIT_3;
            default:      seg_display = SEG_DIGIT_0;
        endcase
    end

    assign led_status = {err_lamp, store_full, err_latched};

    // ====================
    // Instances
    // ====================
    uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (
        .clk(clk), .rst_n(rst_n), .rx(uart_rx), .rx_data(rx_data), .rx_valid(rx_valid)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx (
        .clk(clk), .rst_n(rst_n), .tx_data(tx_data), .tx_start(tx_start),
        .tx(uart_tx), .tx_busy(tx_busy)
    );

    matrix_store u_store (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data),
        .commit(commit), .commit_m(commit_m), .commit_n(commit_n),
        .rd_slot(rd_slot), .rd_index(rd_index), .next_slot(next_slot), .rd_data(rd_data),
        .q_valid(q_valid), .q_m(q_m), .q_n(q_n), .store_full(store_full)
    );

    matrix_input u_input (
        .clk(clk), .rst_n(rst_n), .active(input_active),
        .rx_data(rx_data), .rx_valid(rx_valid), .tx_busy(tx_busy), .next_slot(next_slot),
        .tx_data(in_tx_data), .tx_start(in_tx_start),
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data),
        .commit(commit), .commit_m(commit_m), .commit_n(commit_n),
        .err_strobe(in_err_strobe), .err_code(in_err_code)
    );

    matrix_output u_output (
        .clk(clk), .rst_n(rst_n), .active(display_active),
        .rx_data(rx_data), .rx_valid(rx_valid), .tx_busy(tx_busy),
        .rd_data(rd_data), .q_valid(q_valid), .q_m(q_m), .q_n(q_n),
        .tx_data(out_tx_data), .tx_start(out_tx_start),
        .rd_slot(rd_slot), .rd_index(rd_index),
        .err_strobe(out_err_strobe), .err_code(out_err_code)
    );

endmodule

/* source/matrix_output.sv */
`timescale 1ns/100ps
// Matrix display mode
// Takes a slot request, then streams m, n and the elements in row-major
// order, one byte each time the transmitter goes idle

module matrix_output (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                active,
    input  matcalc_pkg::byte_t  rx_data,
    input  logic                rx_valid,
    input  logic                tx_busy,
    input  matcalc_pkg::elem_t  rd_data,
    input  logic                q_valid,
    input  matcalc_pkg::dim_t   q_m,
    input  matcalc_pkg::dim_t   q_n,
    output matcalc_pkg::byte_t  tx_data,
    output logic                tx_start,
    output matcalc_pkg::slot_t  rd_slot,
    output matcalc_pkg::index_t rd_index,
    output logic                err_strobe,
    output matcalc_pkg::err_t   err_code
);
    import matcalc_pkg::*;

    typedef enum logic [2:0] {
        OUT_IDLE, OUT_CHECK, OUT_SEND_M, OUT_SEND_N, OUT_SEND_E, OUT_FETCH
    } out_state_t;

    out_state_t state;
    byte_t      hdr_byte;
    logic [4:0] elem_total;
    logic       last_elem;

    // rd_slot is held for the whole transfer, so the query stays stable
    assign elem_total = {2'b00, q_m} * {2'b00, q_n};
    assign last_elem  = ({1'b0, rd_index} == elem_total - 5'd1);
    assign tx_start   = (state inside {OUT_SEND_M, OUT_SEND_N, OUT_SEND_E}) && !tx_busy;
    assign tx_data    = (state == OUT_SEND_E) ? rd_data : hdr_byte;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= OUT_IDLE;
            hdr_byte   <= '0;
            rd_slot    <= '0;
            rd_index   <= '0;
            err_strobe <= 1'b0;
            err_code   <= ERR_NONE;
        end else begin
            err_strobe <= 1'b0;
            if (!active) begin
                state <= OUT_IDLE;
            end else begin
                case (state)
                    OUT_IDLE: begin
                        if (rx_valid) begin
                            rd_slot <= rx_data[1:0];
                            state   <= OUT_CHECK;
                        end
                    end
                    OUT_CHECK: begin
                        if (q_valid) begin
                            hdr_byte <= byte_t'(q_m);
                            rd_index <= '0;
                            state    <= OUT_SEND_M;
                        end else begin
                            err_strobe <= 1'b1;
                            err_code   <= ERR_SLOT;
                            state      <= OUT_IDLE;
                        end
                    end
                    OUT_SEND_M: begin
                        if (!tx_busy) begin
                            hdr_byte <= byte_t'(q_n);
                            state    <= OUT_SEND_N;
                        end
                    end
                    OUT_SEND_N: begin
                        if (!tx_busy) state <= OUT_SEND_E;
                    end
                    OUT_SEND_E: begin
                        if (!tx_busy && last_elem) begin
                            state <= OUT_IDLE;
                        end else if (!tx_busy) begin
                            rd_index <= rd_index + 1'b1;
                            state    <= OUT_FETCH;
                        end
                    end
                    // One cycle for the RAM read
                    default: state <= OUT_SEND_E;
                endcase
            end
        end
    end

endmodule

/* source/matrix_input.sv */
`timescale 1ns/100ps
// Matrix input mode
// Takes m, n and m*n elements over UART, checks each against the limits,
// writes the store, commits and answers with the slot number

module matrix_input (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                active,
    input  matcalc_pkg::byte_t  rx_data,
    input  logic                rx_valid,
    input  logic                tx_busy,
    input  matcalc_pkg::slot_t  next_slot,
    output matcalc_pkg::byte_t  tx_data,
    output logic                tx_start,
    output logic                wr_en,
    output matcalc_pkg::index_t wr_index,
    output matcalc_pkg::elem_t  wr_data,
    output logic                commit,
    output matcalc_pkg::dim_t   commit_m,
    output matcalc_pkg::dim_t   commit_n,
    output logic                err_strobe,
    output matcalc_pkg::err_t   err_code
);
    import matcalc_pkg::*;

    typedef enum logic [2:0] {IN_WAIT_M, IN_WAIT_N, IN_ELEM, IN_COMMIT, IN_REPLY} in_state_t;

    in_state_t  state;
    index_t     elem_idx;
    logic [4:0] elem_total;
    logic       dim_ok;
    logic       value_ok;
    logic       last_elem;

    assign dim_ok     = (rx_data != '0) && (rx_data <= byte_t'(MAX_DIM));
    assign value_ok   = (rx_data <= byte_t'(MAX_VALUE));
    // Dimension registers double as the commit outputs
    assign elem_total = {2'b00, commit_m} * {2'b00, commit_n};
    assign last_elem  = ({1'b0, elem_idx} == elem_total - 5'd1);
    assign tx_start   = (state == IN_REPLY) && !tx_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IN_WAIT_M;
            elem_idx   <= '0;
            commit_m   <= '0;
            commit_n   <= '0;
            wr_en      <= 1'b0;
            wr_index   <= '0;
            wr_data    <= '0;
            commit     <= 1'b0;
            tx_data    <= '0;
            err_strobe <= 1'b0;
            err_code   <= ERR_NONE;
        end else begin
            wr_en      <= 1'b0;
            commit     <= 1'b0;
            err_strobe <= 1'b0;
            if (!active) begin
                state <= IN_WAIT_M;
            end else begin
                case (state)
                    IN_WAIT_M: begin
                        if (rx_valid && dim_ok) begin
                            commit_m <= rx_data[2:0];
                            state    <= IN_WAIT_N;
                        end else if (rx_valid) begin
                            err_strobe <= 1'b1;
                            err_code   <= ERR_DIM;
                        end
                    end
                    IN_WAIT_N: begin
                        if (rx_valid && dim_ok) begin
                            commit_n <= rx_data[2:0];
                            elem_idx <= '0;
                            state    <= IN_ELEM;
                        end else if (rx_valid) begin
                            err_strobe <= 1'b1;
                            err_code   <= ERR_DIM;
                            state      <= IN_WAIT_M;
                        end
                    end
                    IN_ELEM: begin
                        // Bad value is dropped, same index waits for a retry
                        if (rx_valid && value_ok) begin
                            wr_en    <= 1'b1;
                            wr_index <= elem_idx;
                            wr_data  <= rx_data;
                            elem_idx <= elem_idx + 1'b1;
                            if (last_elem) state <= IN_COMMIT;
                        end else if (rx_valid) begin
                            err_strobe <= 1'b1;
                            err_code   <= ERR_VALUE;
                        end
                    end
                    IN_COMMIT: begin
                        // next_slot still points at this matrix here
                        commit  <= 1'b1;
                        tx_data <= byte_t'(next_slot);
                        state   <= IN_REPLY;
                    end
                    default: begin
                        if (!tx_busy) state <= IN_WAIT_M;
                    end
                endcase
            end
        end
    end

endmodule

/* source/matrix_store.sv */
`timescale 1ns/100ps
// Matrix store
// Element RAM addressed by slot and index plus a slot table of valid flags
// and dimensions; new matrices go to next_slot, oldest overwritten on wrap

module matrix_store (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  matcalc_pkg::index_t wr_index,
    input  matcalc_pkg::elem_t  wr_data,
    input  logic                commit,
    input  matcalc_pkg::dim_t   commit_m,
    input  matcalc_pkg::dim_t   commit_n,
    input  matcalc_pkg::slot_t  rd_slot,
    input  matcalc_pkg::index_t rd_index,
    output matcalc_pkg::slot_t  next_slot,
    output matcalc_pkg::elem_t  rd_data,
    output logic                q_valid,
    output matcalc_pkg::dim_t   q_m,
    output matcalc_pkg::dim_t   q_n,
    output logic                store_full
);
    import matcalc_pkg::*;

    elem_t                mem [NUM_SLOTS*SLOT_ELEMS];
    logic [NUM_SLOTS-1:0] slot_valid;
    dim_t                 slot_m [NUM_SLOTS];
    dim_t                 slot_n [NUM_SLOTS];
    addr_t                wr_addr;
    addr_t                rd_addr;

    assign wr_addr = {next_slot, wr_index};
    assign rd_addr = {rd_slot, rd_index};

    // ====================
    // Element RAM
    // ====================
    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];
    end

    // ====================
    // Slot table
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= '0;
            next_slot  <= '0;
        end else if (commit) begin
            slot_valid[next_slot] <= 1'b1;
            next_slot             <= next_slot + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            slot_m[next_slot] <= commit_m;
            slot_n[next_slot] <= commit_n;
        end
    end

    // Query side is combinational
    assign q_valid    = slot_valid[rd_slot];
    assign q_m        = slot_m[rd_slot];
    assign q_n        = slot_n[rd_slot];
    assign store_full = &slot_valid;

endmodule

/* source/uart_tx.sv */
`timescale 1ns/100ps
// UART transmitter, 8N1
// Loads a frame on tx_start and stays busy for ten bit periods

module uart_tx #(
    parameter int clks_per_bit = matcalc_pkg::CLKS_PER_BIT_DEFAULT
) (
    input  logic               clk,
    input  logic               rst_n,
    input  matcalc_pkg::byte_t tx_data,
    input  logic               tx_start,
    output logic               tx,
    output logic               tx_busy
);
    typedef logic [$clog2(clks_per_bit)-1:0] baud_cnt_t;

    baud_cnt_t  baud_cnt;
    logic [3:0] bit_cnt;
    // Stop, data, start; shifted out from bit 0
    logic [9:0] frame;

    // Frame refills with ones, so the line idles high
    assign tx = frame[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame    <= '1;
            tx_busy  <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame    <= {1'b1, tx_data, 1'b0};
                tx_busy  <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt == baud_cnt_t'(clks_per_bit - 1)) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[9:1]};
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) tx_busy <= 1'b0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

/* source/uart_rx.sv */
`timescale 1ns/100ps
// UART receiver, 8N1
// Confirms the start bit at mid-bit, samples data LSB first and pulses
// rx_valid in the middle of a good stop bit

module uart_rx #(
    parameter int clks_per_bit = matcalc_pkg::CLKS_PER_BIT_DEFAULT
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rx,
    output matcalc_pkg::byte_t rx_data,
    output logic               rx_valid
);
    import matcalc_pkg::*;

    typedef logic [$clog2(clks_per_bit)-1:0] baud_cnt_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  state;
    logic [1:0] rx_sync;
    baud_cnt_t  baud_cnt;
    logic [2:0] bit_idx;
    byte_t      shift;
    logic       line;
    logic       half_bit;
    logic       bit_end;

    assign line     = rx_sync[1];
    assign half_bit = (baud_cnt == baud_cnt_t'(clks_per_bit / 2 - 1));
    assign bit_end  = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync  <= 2'b11;
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!line) state <= RX_START;
                end
                RX_START: begin
                    // Glitch shorter than half a bit goes back to idle
                    if (half_bit) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= line ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end
                end
                default: begin
                    // Framing error drops the byte
                    if (bit_end) begin
                        rx_valid <= line;
                        state    <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) shift <= {line, shift[7:1]};
        if (state == RX_STOP && bit_end) rx_data <= shift;
    end

endmodule

/* source/matcalc_pkg.sv */
// Matrix calculator shared definitions
// Widths, fixed limits, error codes and the top-level mode encoding

package matcalc_pkg;

    // ====================
    // Data widths
    // ====================
    typedef logic [7:0] byte_t;
    typedef logic [7:0] elem_t;
    typedef logic [2:0] dim_t;
    typedef logic [1:0] slot_t;
    typedef logic [3:0] index_t;
    // Slot in the upper bits, element index below
    typedef logic [5:0] addr_t;

    // ====================
    // Error codes
    // ====================
    typedef logic [1:0] err_t;
    localparam err_t ERR_NONE  = 2'd0;
    localparam err_t ERR_DIM   = 2'd1;
    localparam err_t ERR_VALUE = 2'd2;
    localparam err_t ERR_SLOT  = 2'd3;

    typedef enum logic [1:0] {MODE_MENU, MODE_INPUT, MODE_DISPLAY} mode_t;

    // ====================
    // Limits and timing
    // ====================
    localparam int MAX_DIM    = 4;
    localparam int MAX_VALUE  = 9;
    localparam int NUM_SLOTS  = 4;
    localparam int SLOT_ELEMS = 16;

    localparam int CLK_FREQ             = 100_000_000;
    localparam int BAUD_RATE            = 115_200;
    localparam int CLKS_PER_BIT_DEFAULT = CLK_FREQ / BAUD_RATE;
    // One second on the board clock
    localparam int ERR_HOLD_DEFAULT     = CLK_FREQ;

    // DIP switch codes
    localparam logic [2:0] SW_INPUT   = 3'd1;
    localparam logic [2:0] SW_DISPLAY = 3'd3;

    // Segments gfedcba, lit when high
    localparam logic [6:0] SEG_DIGIT_0 = 7'b011_1111;
    localparam logic [6:0] SEG_DIGIT_1 = 7'b000_0110;
    localparam logic [6:0] SEG_DIGIT_3 = 7'b100_1111;

endpackage
